/* Bender.yml */
package:
  name: lsu

export_include_dirs:
  - hw

sources:
  - files:
      - hw/lsu_pkg.sv
      - hw/credit_fifo.sv
      - hw/agu.sv
      - hw/lsu_ctrl.sv
      - hw/dmem.sv
      - hw/lsu_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - dv/lsu_chk.sv
      - dv/lsu_tb.sv

/* build.f */
+incdir+hw
hw/lsu_pkg.sv
hw/credit_fifo.sv
hw/agu.sv
hw/lsu_ctrl.sv
hw/dmem.sv
hw/lsu_top.sv
dv/lsu_chk.sv
dv/lsu_tb.sv

/* dv/lsu_chk.sv */
`timescale 1ns/10ps
`default_nettype none

`include "lsu_config.svh"

module lsu_chk #(
  parameter int REQ_CW = $clog2(`LSU_REQ_DEPTH + 1),
  parameter int RES_CW = $clog2(`LSU_RESULT_CREDITS + 1)
) (
  input logic                 clock,
  input logic                 rst_n,
  input logic                 req_valid,
  input lsu_pkg::mem_req_type req,
  input logic [REQ_CW-1:0]    req_credits,
  input logic                 result_valid,
  input logic [RES_CW-1:0]    result_credits
);

  import lsu_pkg::*;

  logic error_seen;

  initial error_seen = 1'b0;

  // ****************************************
  // Credit discipline
  // ****************************************

  req_needs_credit: assert property (
    @(posedge clock) disable iff (!rst_n) req_valid |-> (req_credits != '0)
  ) else begin
    $error("request sent while the request credit count was zero");
    error_seen = 1'b1;
  end

  result_needs_credit: assert property (
    @(posedge clock) disable iff (!rst_n) result_valid |-> (result_credits != '0)
  ) else begin
    $error("result sent while the result credit count was zero");
    error_seen = 1'b1;
  end

  // Faulting access must not touch memory
  fault_no_bytes: assert property (
    @(posedge clock) disable iff (!rst_n)
      (req_valid && req.tag.exception) |-> (req.byteenable == 8'h00)
  ) else begin
    $error("faulting request carries byte enables");
    error_seen = 1'b1;
  end

endmodule

bind lsu_ctrl lsu_chk u_lsu_chk (
  .clock          (clock),
  .rst_n          (rst_n),
  .req_valid      (req_valid),
  .req            (req),
  .req_credits    (req_credits),
  .result_valid   (result_valid),
  .result_credits (result_credits)
);

`default_nettype wire

/* dv/lsu_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "lsu_config.svh"

module lsu_tb;

  import lsu_pkg::*;

  localparam int N_ADDR  = 200;
  localparam int N_SL    = 60;  // Six operations each
  localparam int N_MIS   = 80;  // Two operations each
  localparam int N_BP    = 150;
  localparam int N_MIXED = 2000;
  localparam int TOTAL_OPS = N_ADDR + 6 * N_SL + 2 * N_MIS + N_BP + N_MIXED;

  logic        clock;
  logic        rst_n;
  logic        op_valid;
  op_type      op;
  logic        op_credit;
  logic        result_valid;
  result_type  result;
  logic        result_credit;

  logic [63:0] model_mem [1 << `DMEM_WORDS_LOG2];
  result_type  expected_q [$];
  int          op_sent;
  int          op_returned;
  int          owed;
  int          delay;
  logic        hold_results;
  string       test_name;
  int unsigned seed;

  lsu_top dut (
    .clock         (clock),
    .rst_n         (rst_n),
    .op_valid      (op_valid),
    .op            (op),
    .op_credit     (op_credit),
    .result_valid  (result_valid),
    .result        (result),
    .result_credit (result_credit)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Test FAILED");
    $fatal(1, "simulation stopped after an error");
  endtask

  // ****************************************
  // Compare tasks
  // ****************************************

  function automatic string format_result(input result_type r);
    return $sformatf("addr=%h rdata=%h exc=%b cause=%0d tval=%h",
                     r.address, r.rdata, r.exception, r.ecause, r.etval);
  endfunction

  task automatic check_result(input result_type exp, input result_type act);
    if (act !== exp) begin
      report_failure($sformatf("CHECK FAILED %s: expected %s, actual %s",
                               test_name, format_result(exp), format_result(act)));
    end
  endtask

  task automatic check_credits(input int exp, input int act);
    if (act != exp) begin
      report_failure($sformatf("CHECK FAILED %s: expected %0d operation credits, actual %0d",
                               test_name, exp, act));
    end
  endtask

  // ****************************************
  // Reference model
  // ****************************************

  function automatic int access_bytes(input bit is_store, input int w);
    if (is_store) return (w == 0) ? 1 : (w == 1) ? 2 : 4;
    return (w < 2) ? 1 : (w < 4) ? 2 : 4;
  endfunction

  function automatic result_type model_op(input op_type o);
    result_type  r;
    logic [31:0] a;
    logic [63:0] w;
    logic [31:0] v;
    int          size;
    int          off;
    r = '0;
    a = (o.auipc || o.jal || o.branch) ? o.pc + o.imm : o.rdata1 + o.imm;
    if (o.jalr) a[0] = 1'b0;
    r.address = a;
    size = (o.lsu_op.lsu_lw | o.lsu_op.lsu_sw) ? 4 :
           (o.lsu_op.lsu_lh | o.lsu_op.lsu_lhu | o.lsu_op.lsu_sh) ? 2 : 1;
    if (o.jal || o.jalr || o.branch) begin
      if (a[0]) begin
        r.exception = 1'b1;
        r.ecause    = except_instr_addr_misalign;
        r.etval     = a;
      end
    end else if (o.load || o.store) begin
      if (a % size != 0) begin
        r.exception = 1'b1;
        r.ecause    = o.load ? except_load_addr_misalign : except_store_addr_misalign;
        r.etval     = a;
      end else begin
        off = a[2:0];
        w   = model_mem[a[3 +: `DMEM_WORDS_LOG2]];
        if (o.store) begin
          for (int i = 0; i < size; i++) w[(off + i) * 8 +: 8] = o.rdata2[i * 8 +: 8];
          model_mem[a[3 +: `DMEM_WORDS_LOG2]] = w;
        end else begin
          v = '0;
          for (int i = 0; i < size; i++) v[i * 8 +: 8] = w[(off + i) * 8 +: 8];
          if ((o.lsu_op.lsu_lb || o.lsu_op.lsu_lh) && v[size * 8 - 1]) begin
            for (int i = size * 8; i < 32; i++) v[i] = 1'b1; // Sign extension
          end
          r.rdata = v;
        end
      end
    end
    return r;
  endfunction

  // ****************************************
  // Stimulus
  // ****************************************

  function automatic op_type flow_op(input int kind);
    op_type o;
    o = '0;
    o.pc     = $urandom;
    o.rdata1 = $urandom;
    o.rdata2 = $urandom;
    o.imm    = $urandom;
    case (kind)
      0:       o.jal    = 1'b1;
      1:       o.jalr   = 1'b1;
      2:       o.branch = 1'b1;
      default: o.auipc  = 1'b1;
    endcase
    return o;
  endfunction

  function automatic op_type mem_op(input bit is_store, input int w, input logic [31:0] addr);
    op_type      o;
    logic [11:0] imm12;
    o     = '0;
    imm12 = 12'($urandom);
    o.load  = !is_store;
    o.store = is_store;
    if (is_store) begin
      o.lsu_op.lsu_sb = (w == 0);
      o.lsu_op.lsu_sh = (w == 1);
      o.lsu_op.lsu_sw = (w == 2);
    end else begin
      o.lsu_op.lsu_lb  = (w == 0);
      o.lsu_op.lsu_lbu = (w == 1);
      o.lsu_op.lsu_lh  = (w == 2);
      o.lsu_op.lsu_lhu = (w == 3);
      o.lsu_op.lsu_lw  = (w == 4);
    end
    o.pc     = $urandom;
    o.imm    = {{20{imm12[11]}}, imm12};
    o.rdata1 = addr - o.imm;
    o.rdata2 = $urandom;
    return o;
  endfunction

  function automatic op_type random_op();
    int          kind;
    int          w;
    bit          st;
    logic [31:0] addr;
    kind = $urandom_range(9);
    if (kind < 4) return flow_op(kind);
    st   = (kind >= 7);
    w    = st ? $urandom_range(2) : $urandom_range(4);
    addr = $urandom;
    if ($urandom_range(3) != 0) addr = addr & ~32'(access_bytes(st, w) - 1); // Mostly aligned
    return mem_op(st, w, addr);
  endfunction

  task automatic send_op(input op_type o);
    @(posedge clock);
    if ($urandom_range(3) == 0) begin
      op_valid <= 1'b0;
      @(posedge clock);
    end
    while (op_sent - op_returned >= `LSU_OP_DEPTH) begin
      op_valid <= 1'b0;
      @(posedge clock);
    end
    op_valid <= 1'b1;
    op       <= o;
    op_sent++;
    expected_q.push_back(model_op(o));
  endtask

  task automatic drain();
    @(posedge clock);
    op_valid <= 1'b0;
    while (expected_q.size() != 0) @(posedge clock);
    repeat (2) @(posedge clock);
  endtask

  // Result consumer returning credits after a random delay
  always @(posedge clock) begin
    if (rst_n) begin
      if (op_credit) op_returned <= op_returned + 1;
      if (result_valid) begin
        if (expected_q.size() == 0) begin
          report_failure("Result arrived with no operation outstanding");
        end else begin
          check_result(expected_q.pop_front(), result);
          owed++;
        end
      end
      result_credit <= 1'b0;
      if (delay > 0) begin
        delay--;
      end else if (owed > 0) begin
        result_credit <= 1'b1;
        owed--;
        delay = hold_results ? $urandom_range(60, 20) : $urandom_range(3);
      end
      if (dut.u_lsu_ctrl.u_lsu_chk.error_seen) begin
        report_failure("An assertion on the controller fired");
      end
    end
  end

  initial begin
    repeat (200 * TOTAL_OPS) @(posedge clock);
    report_failure("Timeout, the DUT stopped returning results");
  end

  initial begin
    logic [31:0] base;
    int          size;
    int          off;
    int          w;
    seed = 32'hb665;
    void'($urandom(seed));
    op_valid      = 1'b0;
    op            = '0;
    result_credit = 1'b0;
    rst_n         = 1'b0;
    hold_results  = 1'b0;
    op_sent       = 0;
    op_returned   = 0;
    owed          = 0;
    delay         = 0;
    for (int i = 0; i < (1 << `DMEM_WORDS_LOG2); i++) model_mem[i] = 64'd0;
    repeat (3) @(posedge clock);
    rst_n <= 1'b1;

    test_name = "addr_gen";
    for (int n = 0; n < N_ADDR; n++) send_op(flow_op($urandom_range(3)));
    drain();

    test_name = "store_load";
    for (int n = 0; n < N_SL; n++) begin
      base = {29'($urandom), 3'b000};
      w    = $urandom_range(2);
      size = access_bytes(1'b1, w);
      send_op(mem_op(1'b1, w, base + ($urandom_range(7) & ~(size - 1))));
      for (int lw = 0; lw < 5; lw++) begin
        size = access_bytes(1'b0, lw);
        send_op(mem_op(1'b0, lw, base + ($urandom_range(7) & ~(size - 1))));
      end
    end
    drain();

    test_name = "misalign";
    for (int n = 0; n < N_MIS; n++) begin
      base = {29'($urandom), 3'b000};
      w    = $urandom_range(4);
      off  = (w == 2 || w == 4) ? $urandom_range(7) : ($urandom_range(3) * 2 + 1);
      if ((w == 2 || w == 4) && off % 4 == 0) off++;
      case (w)
        0:       send_op(mem_op(1'b0, 2, base + off));
        1:       send_op(mem_op(1'b0, 3, base + off));
        2:       send_op(mem_op(1'b0, 4, base + off));
        3:       send_op(mem_op(1'b1, 1, base + off));
        default: send_op(mem_op(1'b1, 2, base + off));
      endcase
      send_op(mem_op(1'b0, 4, base + (off & ~3))); // Word must be unchanged
    end
    drain();

    test_name = "back_pressure";
    hold_results <= 1'b1;
    for (int n = 0; n < N_BP; n++) send_op(random_op());
    drain();
    hold_results <= 1'b0;
    check_credits(`LSU_OP_DEPTH, `LSU_OP_DEPTH - (op_sent - op_returned));

    test_name = "mixed";
    for (int n = 0; n < N_MIXED; n++) send_op(random_op());
    drain();
    check_credits(`LSU_OP_DEPTH, `LSU_OP_DEPTH - (op_sent - op_returned));

    if (dut.u_lsu_ctrl.u_lsu_chk.error_seen) begin
      report_failure("An assertion on the controller fired");
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* hw/agu.sv */
`timescale 1ns/10ps
`default_nettype none

module agu (
  input  lsu_pkg::agu_in_type  agu_in,
  output lsu_pkg::agu_out_type agu_out
);

  import lsu_pkg::*;

  logic        imem_access;
  logic        dmem_access;
  logic        width_b;
  logic        width_h;
  logic        width_w;
  logic        misalign;
  logic [31:0] base;
  logic [31:0] address;
  logic [7:0]  byteenable;
  logic [3:0]  ecause;

  always_comb begin
    imem_access = agu_in.jal | agu_in.jalr | agu_in.branch;
    dmem_access = agu_in.load | agu_in.store;

    width_b = agu_in.lsu_op.lsu_lb | agu_in.lsu_op.lsu_lbu | agu_in.lsu_op.lsu_sb;
    width_h = agu_in.lsu_op.lsu_lh | agu_in.lsu_op.lsu_lhu | agu_in.lsu_op.lsu_sh;
    width_w = agu_in.lsu_op.lsu_lw | agu_in.lsu_op.lsu_sw;

    // pc-relative or register-relative
    base    = (agu_in.auipc | agu_in.jal | agu_in.branch) ? agu_in.pc : agu_in.rdata1;
    address = base + agu_in.imm;
    if (agu_in.jalr) address[0] = 1'b0;

    misalign   = 1'b0;
    byteenable = '0;

    if (imem_access) begin
      misalign   = address[0];
      byteenable = 8'hFF;
    end else if (dmem_access) begin
      if (width_b) begin
        byteenable = 8'h01 << address[2:0];
      end else if (width_h) begin
        misalign   = address[0];
        byteenable = 8'h03 << address[2:0];
      end else if (width_w) begin
        misalign   = |address[1:0];
        byteenable = 8'h0F << address[2:0];
      end
    end

    if (imem_access) begin
      ecause = except_instr_addr_misalign;
    end else if (agu_in.load) begin
      ecause = except_load_addr_misalign;
    end else begin
      ecause = except_store_addr_misalign;
    end

    // Faulting access touches nothing
    if (misalign) byteenable = '0;

    agu_out.address    = address;
    agu_out.byteenable = byteenable;
    agu_out.exception  = misalign;
    agu_out.ecause     = misalign ? ecause : 4'd0;
    agu_out.etval      = misalign ? address : 32'd0;
  end

endmodule

`default_nettype wire

/* hw/credit_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module credit_fifo #(
  parameter type payload_type = logic [7:0],
  parameter int  DEPTH        = 4
) (
  input  logic        clock,
  input  logic        rst_n,
  input  logic        push,
  input  payload_type push_data,
  input  logic        pop,
  output payload_type pop_data,
  output logic        not_empty,
  output logic        credit
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_type buffer [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_pop;
  logic             credit_q;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign do_pop = pop & not_empty;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      credit_q <= 1'b0;
    end else begin
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (do_pop) rd_ptr <= next_ptr(rd_ptr);
      count    <= count + CNT_W'(push) - CNT_W'(do_pop);
      credit_q <= do_pop; // One credit per popped entry
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      buffer[wr_ptr] <= push_data;
    end
  end

  assign pop_data  = buffer[rd_ptr];
  assign not_empty = (count != '0);
  assign credit    = credit_q;

endmodule

`default_nettype wire

/* hw/dmem.sv */
`timescale 1ns/10ps
`default_nettype none

`include "lsu_config.svh"

module dmem (
  input  logic                  clock,
  input  logic                  rst_n,
  input  logic                  req_valid,
  input  lsu_pkg::mem_req_type  req,
  output logic                  req_credit,
  output logic                  resp_valid,
  output lsu_pkg::mem_resp_type resp,
  input  logic                  resp_credit
);

  import lsu_pkg::*;

  localparam int WORDS   = 1 << `DMEM_WORDS_LOG2;
  localparam int RESP_CW = $clog2(`LSU_RESP_DEPTH + 1);

  logic [63:0]                mem [WORDS];
  mem_req_type                head;
  logic                       req_avail;
  logic                       pop;
  logic [`DMEM_WORDS_LOG2-1:0] idx;
  logic [RESP_CW-1:0]         resp_credits;
  logic                       resp_valid_q;
  mem_resp_type               resp_q;

  credit_fifo #(
    .payload_type (mem_req_type),
    .DEPTH        (`LSU_REQ_DEPTH)
  ) u_req_fifo (
    .clock     (clock),
    .rst_n     (rst_n),
    .push      (req_valid),
    .push_data (req),
    .pop       (pop),
    .pop_data  (head),
    .not_empty (req_avail),
    .credit    (req_credit)
  );

  assign pop = req_avail & (resp_credits != '0); // Stall without response room
  assign idx = head.index[`DMEM_WORDS_LOG2-1:0];  // Wraps within the array

  initial begin
    for (int w = 0; w < WORDS; w++) begin
      mem[w] = 64'd0;
    end
  end

  // Byte-enabled write
  always @(posedge clock) begin
    if (pop && head.write) begin
      for (int i = 0; i < 8; i++) begin
        if (head.byteenable[i]) mem[idx][i*8 +: 8] <= head.wdata[i*8 +: 8];
      end
    end
  end

  // Old word goes back with the tag
  always_ff @(posedge clock) begin
    if (pop) begin
      resp_q.rdata <= mem[idx];
      resp_q.tag   <= head.tag;
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      resp_valid_q <= 1'b0;
      resp_credits <= RESP_CW'(`LSU_RESP_DEPTH);
    end else begin
      resp_valid_q <= pop;
      resp_credits <= resp_credits - RESP_CW'(pop) + RESP_CW'(resp_credit);
    end
  end

  assign resp_valid = resp_valid_q;
  assign resp       = resp_q;

endmodule

`default_nettype wire

/* hw/lsu_config.svh */
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// ****************************************
// Buffer depths and credit counts
// ****************************************

// Operation buffer depth and initial operation credits
`define LSU_OP_DEPTH 4

// Memory request buffer inside dmem
`define LSU_REQ_DEPTH 4

// Response buffer inside the controller
`define LSU_RESP_DEPTH 4

// Results the consumer can take before returning credit
`define LSU_RESULT_CREDITS 2

// ****************************************
// Data memory
// ****************************************

`define DMEM_WORDS_LOG2 6 // 64 words of 64 bits

`endif

/* hw/lsu_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

`include "lsu_config.svh"

module lsu_ctrl (
  input  logic                  clock,
  input  logic                  rst_n,
  input  logic                  op_avail,
  input  lsu_pkg::op_type       op,
  input  lsu_pkg::agu_out_type  agu_res,
  output logic                  op_pop,
  output logic                  req_valid,
  output lsu_pkg::mem_req_type  req,
  input  logic                  req_credit,
  input  logic                  resp_valid,
  input  lsu_pkg::mem_resp_type resp,
  output logic                  resp_credit,
  output logic                  result_valid,
  output lsu_pkg::result_type   result,
  input  logic                  result_credit
);

  import lsu_pkg::*;

  localparam int REQ_CW = $clog2(`LSU_REQ_DEPTH + 1);
  localparam int RES_CW = $clog2(`LSU_RESULT_CREDITS + 1);

  logic [REQ_CW-1:0] req_credits;
  logic [RES_CW-1:0] result_credits;
  logic              issue;
  logic              resp_avail;
  mem_resp_type      resp_head;
  logic [63:0]       lane;
  logic [31:0]       rdata;

  // ****************************************
  // Request side
  // ****************************************

  assign issue     = op_avail & (req_credits != '0);
  assign op_pop    = issue;
  assign req_valid = issue;

  always_comb begin
    req.index      = agu_res.address[31:3];
    req.byteenable = (op.load | op.store) ? agu_res.byteenable : 8'h00;
    req.write      = op.store & ~agu_res.exception;
    req.wdata      = '0;
    if (op.lsu_op.lsu_sb) req.wdata = {8{op.rdata2[7:0]}};
    if (op.lsu_op.lsu_sh) req.wdata = {4{op.rdata2[15:0]}};
    if (op.lsu_op.lsu_sw) req.wdata = {2{op.rdata2}};

    req.tag.lsu_op    = op.load ? op.lsu_op : '0; // Only loads return data
    req.tag.address   = agu_res.address;
    req.tag.exception = agu_res.exception;
    req.tag.ecause    = agu_res.ecause;
    req.tag.etval     = agu_res.etval;
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      req_credits <= REQ_CW'(`LSU_REQ_DEPTH);
    end else begin
      req_credits <= req_credits - REQ_CW'(issue) + REQ_CW'(req_credit);
    end
  end

  // ****************************************
  // Response side
  // ****************************************

  credit_fifo #(
    .payload_type (mem_resp_type),
    .DEPTH        (`LSU_RESP_DEPTH)
  ) u_resp_fifo (
    .clock     (clock),
    .rst_n     (rst_n),
    .push      (resp_valid),
    .push_data (resp),
    .pop       (result_valid),
    .pop_data  (resp_head),
    .not_empty (resp_avail),
    .credit    (resp_credit)
  );

  assign result_valid = resp_avail & (result_credits != '0);

  always_comb begin
    lane  = resp_head.rdata >> {resp_head.tag.address[2:0], 3'b000};
    rdata = '0;
    if (!resp_head.tag.exception) begin
      if (resp_head.tag.lsu_op.lsu_lb)  rdata = {{24{lane[7]}}, lane[7:0]};
      if (resp_head.tag.lsu_op.lsu_lbu) rdata = {24'd0, lane[7:0]};
      if (resp_head.tag.lsu_op.lsu_lh)  rdata = {{16{lane[15]}}, lane[15:0]};
      if (resp_head.tag.lsu_op.lsu_lhu) rdata = {16'd0, lane[15:0]};
      if (resp_head.tag.lsu_op.lsu_lw)  rdata = lane[31:0];
    end

    result.address   = resp_head.tag.address;
    result.rdata     = rdata;
    result.exception = resp_head.tag.exception;
    result.ecause    = resp_head.tag.ecause;
    result.etval     = resp_head.tag.etval;
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      result_credits <= RES_CW'(`LSU_RESULT_CREDITS);
    end else begin
      result_credits <= result_credits - RES_CW'(result_valid) + RES_CW'(result_credit);
    end
  end

endmodule

`default_nettype wire

/* hw/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

  // One-hot load/store width
  typedef struct packed {
    logic lsu_lb;
    logic lsu_lbu;
    logic lsu_lh;
    logic lsu_lhu;
    logic lsu_lw;
    logic lsu_sb;
    logic lsu_sh;
    logic lsu_sw;
  } lsu_op_type;

  typedef struct packed {
    logic        load;
    logic        store;
    logic        jal;
    logic        jalr;
    logic        branch;
    logic        auipc;
    lsu_op_type  lsu_op;
    logic [31:0] pc;
    logic [31:0] rdata1;
    logic [31:0] rdata2;
    logic [31:0] imm;
  } op_type;

  // Address-related part of an operation
  typedef struct packed {
    logic        load;
    logic        store;
    logic        jal;
    logic        jalr;
    logic        branch;
    logic        auipc;
    lsu_op_type  lsu_op;
    logic [31:0] pc;
    logic [31:0] rdata1;
    logic [31:0] imm;
  } agu_in_type;

  typedef struct packed {
    logic [31:0] address;
    logic [7:0]  byteenable;
    logic        exception;
    logic [3:0]  ecause;
    logic [31:0] etval;
  } agu_out_type;

  // Travels through memory untouched
  typedef struct packed {
    lsu_op_type  lsu_op;
    logic [31:0] address; // Low three bits give the lane offset
    logic        exception;
    logic [3:0]  ecause;
    logic [31:0] etval;
  } mem_tag_type;

  typedef struct packed {
    logic [28:0] index; // 64-bit word index
    logic [7:0]  byteenable;
    logic        write;
    logic [63:0] wdata;
    mem_tag_type tag;
  } mem_req_type;

  typedef struct packed {
    logic [63:0] rdata;
    mem_tag_type tag;
  } mem_resp_type;

  typedef struct packed {
    logic [31:0] address;
    logic [31:0] rdata;
    logic        exception;
    logic [3:0]  ecause;
    logic [31:0] etval;
  } result_type;

  // ****************************************
  // Exception causes
  // ****************************************

  localparam logic [3:0] except_instr_addr_misalign = 4'd0;
  localparam logic [3:0] except_load_addr_misalign  = 4'd4;
  localparam logic [3:0] except_store_addr_misalign = 4'd6;

endpackage

`default_nettype wire

/* hw/lsu_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "lsu_config.svh"

module lsu_top (
  input  logic                clock,
  input  logic                rst_n,
  input  logic                op_valid,
  input  lsu_pkg::op_type     op,
  output logic                op_credit,
  output logic                result_valid,
  output lsu_pkg::result_type result,
  input  logic                result_credit
);

  import lsu_pkg::*;

  op_type       op_head;
  logic         op_avail;
  logic         op_pop;
  agu_in_type   agu_in;
  agu_out_type  agu_res;
  logic         req_valid;
  mem_req_type  req;
  logic         req_credit;
  logic         resp_valid;
  mem_resp_type resp;
  logic         resp_credit;

  credit_fifo #(
    .payload_type (op_type),
    .DEPTH        (`LSU_OP_DEPTH)
  ) u_op_fifo (
    .clock     (clock),
    .rst_n     (rst_n),
    .push      (op_valid),
    .push_data (op),
    .pop       (op_pop),
    .pop_data  (op_head),
    .not_empty (op_avail),
    .credit    (op_credit)
  );

  // Head entry straight into the AGU
  assign agu_in.load   = op_head.load;
  assign agu_in.store  = op_head.store;
  assign agu_in.jal    = op_head.jal;
  assign agu_in.jalr   = op_head.jalr;
  assign agu_in.branch = op_head.branch;
  assign agu_in.auipc  = op_head.auipc;
  assign agu_in.lsu_op = op_head.lsu_op;
  assign agu_in.pc     = op_head.pc;
  assign agu_in.rdata1 = op_head.rdata1;
  assign agu_in.imm    = op_head.imm;

  agu u_agu (
    .agu_in  (agu_in),
    .agu_out (agu_res)
  );

  lsu_ctrl u_lsu_ctrl (
    .clock         (clock),
    .rst_n         (rst_n),
    .op_avail      (op_avail),
    .op            (op_head),
    .agu_res       (agu_res),
    .op_pop        (op_pop),
    .req_valid     (req_valid),
    .req           (req),
    .req_credit    (req_credit),
    .resp_valid    (resp_valid),
    .resp          (resp),
    .resp_credit   (resp_credit),
    .result_valid  (result_valid),
    .result        (result),
    .result_credit (result_credit)
  );

  dmem u_dmem (
    .clock       (clock),
    .rst_n       (rst_n),
    .req_valid   (req_valid),
    .req         (req),
    .req_credit  (req_credit),
    .resp_valid  (resp_valid),
    .resp        (resp),
    .resp_credit (resp_credit)
  );

endmodule

`default_nettype wire
